/* rtl/am_pkg.sv */
package am_pkg;

        localparam int N_LANES    = 4;
        localparam int NB_BLOCK   = 66;
        localparam int NB_AM      = 48;
        localparam int NB_WB_DATA = 32;
        localparam int NB_WB_ADR  = 4;
        localparam int NB_LANE_ID = $clog2(N_LANES);

        typedef logic [NB_BLOCK-1:0]   block_t;
        typedef logic [NB_AM-1:0]      am_pattern_t;
        typedef logic [NB_LANE_ID-1:0] lane_id_t;
        typedef logic [15:0]           err_cnt_t;
        typedef logic [7:0]            resync_cnt_t;
        typedef logic [15:0]           am_period_t;
        typedef logic [4:0]            valid_thr_t;
        typedef logic [2:0]            inval_thr_t;
        typedef logic [NB_WB_DATA-1:0] wb_data_t;
        typedef logic [NB_WB_ADR-1:0]  wb_adr_t;

        localparam logic [1:0] SYNC_CTRL = 2'b10;              // Header of a control block.

        // One marker per logical lane, compared against payload bits 47:0.
        localparam am_pattern_t AM_PATTERNS [N_LANES] = '{
                48'hc1_68_21_3e_97_de,
                48'h9d_71_8e_62_8e_71,
                48'h59_4b_e8_a6_b4_17,
                48'h4d_95_7b_b2_6a_84
        };

        localparam wb_adr_t ADR_CTRL      = 4'd0;
        localparam wb_adr_t ADR_THR       = 4'd1;
        localparam wb_adr_t ADR_MASK_LO   = 4'd2;
        localparam wb_adr_t ADR_MASK_HI   = 4'd3;
        localparam wb_adr_t ADR_PERIOD    = 4'd4;
        localparam wb_adr_t ADR_STATUS    = 4'd5;
        localparam wb_adr_t ADR_LANE_CNT0 = 4'd6;               // One word per lane from here.

        localparam int STATUS_ALIGNED_BIT = 4;
        localparam int STATUS_ID_LSB      = 8;

        typedef struct packed {
                logic        enable;
                valid_thr_t  valid_thr;
                inval_thr_t  inval_thr;
                am_pattern_t mask;
                am_period_t  period;
        } am_cfg_t;

        typedef struct packed {
                logic        am_lock;
                lane_id_t    lane_id;
                err_cnt_t    err_cnt;
                resync_cnt_t resync_cnt;
        } lane_status_t;

        typedef struct packed {
                logic     cyc;
                logic     stb;
                logic     we;
                wb_adr_t  adr;
                wb_data_t dat;
        } wb_req_t;

        typedef struct packed {
                logic     ack;
                wb_data_t dat;
        } wb_rsp_t;

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_SEARCH,
                ST_CONFIRM,
                ST_LOCKED
        } lock_state_e;

endpackage

/* rtl/am_csr_wb.sv */
module am_csr_wb
        import am_pkg::*;
(
        input  logic         i_clock,
        input  logic         i_rst_n,
        input  wb_req_t      i_wb,
        output wb_rsp_t      o_wb,
        input  lane_status_t i_status [N_LANES],
        input  logic         i_all_aligned,
        output am_cfg_t      o_cfg
);

        logic     ack;
        logic     req;
        logic     wr_en;
        wb_data_t rd_data;
        wb_data_t rd_q;

        assign req   = i_wb.cyc && i_wb.stb && !ack;        // Held request is taken once.
        assign wr_en = req && i_wb.we;
        assign o_wb  = '{ack: ack, dat: rd_q};

        always_comb
        begin
                rd_data = '0;
                case (i_wb.adr)
                ADR_CTRL:    rd_data[0]     = o_cfg.enable;
                ADR_THR:
                begin
                        rd_data[4:0]  = o_cfg.valid_thr;
                        rd_data[10:8] = o_cfg.inval_thr;
                end
                ADR_MASK_LO: rd_data        = o_cfg.mask[NB_WB_DATA-1:0];
                ADR_MASK_HI: rd_data[15:0]  = o_cfg.mask[NB_AM-1:NB_WB_DATA];
                ADR_PERIOD:  rd_data[15:0]  = o_cfg.period;
                ADR_STATUS:
                begin
                        rd_data[STATUS_ALIGNED_BIT] = i_all_aligned;
                        for (int l = 0; l < N_LANES; l++)
                        begin
                                rd_data[l] = i_status[l].am_lock;
                                rd_data[STATUS_ID_LSB + NB_LANE_ID*l +: NB_LANE_ID] =
                                        i_status[l].lane_id;
                        end
                end
                default:
                begin
                        for (int l = 0; l < N_LANES; l++)
                        begin
                                if (i_wb.adr == wb_adr_t'(ADR_LANE_CNT0 + l))
                                begin
                                        rd_data[15:0]  = i_status[l].err_cnt;
                                        rd_data[23:16] = i_status[l].resync_cnt;
                                end
                        end
                end
                endcase
        end

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        ack   <= 1'b0;
                        o_cfg <= '0;                            // Lanes stay idle until enabled.
                end
                else
                begin
                        ack <= req;
                        if (wr_en)
                        begin
                                case (i_wb.adr)
                                ADR_CTRL:    o_cfg.enable <= i_wb.dat[0];
                                ADR_THR:
                                begin
                                        o_cfg.valid_thr <= i_wb.dat[4:0];
                                        o_cfg.inval_thr <= i_wb.dat[10:8];
                                end
                                ADR_MASK_LO: o_cfg.mask[NB_WB_DATA-1:0]     <= i_wb.dat;
                                ADR_MASK_HI: o_cfg.mask[NB_AM-1:NB_WB_DATA] <= i_wb.dat[15:0];
                                ADR_PERIOD:  o_cfg.period <= i_wb.dat[15:0];
                                default:     ;                  // Status and counters are read only.
                                endcase
                        end
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (req)
                        rd_q <= rd_data;
        end

endmodule

/* rtl/am_lock_lane.sv */
module am_lock_lane
        import am_pkg::*;
(
        input  logic         i_clock,
        input  logic         i_rst_n,
        input  am_cfg_t      i_cfg,
        input  logic         i_valid,
        input  logic         i_block_lock,
        input  block_t       i_data,
        output logic         o_valid,
        output block_t       o_data,
        output lane_status_t o_status,
        output logic         o_resync,
        output logic         o_start_of_lane
);

        lock_state_e        state;
        logic [N_LANES-1:0] is_am;
        logic               any_am;
        lane_id_t           hit_id;
        lane_id_t           lane_id;
        logic               id_match;
        logic               expected;
        logic               run;
        am_period_t         period_cnt;
        valid_thr_t         good_cnt;
        valid_thr_t         good_nxt;
        inval_thr_t         bad_cnt;
        inval_thr_t         bad_nxt;
        err_cnt_t           err_cnt;
        resync_cnt_t        resync_cnt;

        // Masked compare of the block against every logical lane marker.
        always_comb
        begin
                hit_id = '0;
                for (int k = N_LANES - 1; k >= 0; k--)
                begin
                        is_am[k] = (i_data[NB_BLOCK-1 -: 2] == SYNC_CTRL) &&
                                   (((i_data[NB_AM-1:0] ^ AM_PATTERNS[k]) & i_cfg.mask) == '0);
                        if (is_am[k])
                                hit_id = lane_id_t'(k);         // Lowest id wins.
                end
        end

        assign any_am   = |is_am;
        assign id_match = is_am[lane_id];
        assign expected = (period_cnt == i_cfg.period);
        assign run      = i_cfg.enable && i_block_lock;
        assign good_nxt = good_cnt + 1'b1;
        assign bad_nxt  = bad_cnt + 1'b1;

        assign o_status = '{am_lock:    (state == ST_LOCKED),
                            lane_id:    lane_id,
                            err_cnt:    err_cnt,
                            resync_cnt: resync_cnt};

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        state           <= ST_IDLE;
                        lane_id         <= '0;
                        period_cnt      <= '0;
                        good_cnt        <= '0;
                        bad_cnt         <= '0;
                        err_cnt         <= '0;
                        resync_cnt      <= '0;
                        o_valid         <= 1'b0;
                        o_resync        <= 1'b0;
                        o_start_of_lane <= 1'b0;
                end
                else
                begin
                        o_valid         <= i_valid;
                        o_resync        <= 1'b0;
                        o_start_of_lane <= 1'b0;
                        if (!run)
                        begin
                                state   <= ST_IDLE;             // Counters are kept.
                                bad_cnt <= '0;
                        end
                        else if (state == ST_IDLE)
                                state <= ST_SEARCH;
                        else if (i_valid)
                        begin
                                period_cnt <= expected ? am_period_t'(1) : period_cnt + 1'b1;
                                case (state)
                                ST_SEARCH:
                                begin
                                        if (any_am)
                                        begin
                                                lane_id    <= hit_id;
                                                good_cnt   <= valid_thr_t'(1);
                                                period_cnt <= am_period_t'(1);
                                                state      <= (i_cfg.valid_thr <= valid_thr_t'(1)) ?
                                                              ST_LOCKED : ST_CONFIRM;
                                        end
                                end
                                ST_CONFIRM:
                                begin
                                        if (expected && !id_match)
                                                state <= ST_SEARCH;
                                        else if (expected)
                                        begin
                                                good_cnt <= good_nxt;
                                                if (good_nxt >= i_cfg.valid_thr)
                                                        state <= ST_LOCKED;
                                        end
                                end
                                ST_LOCKED:
                                begin
                                        if (expected && id_match)
                                        begin
                                                bad_cnt         <= '0;
                                                o_start_of_lane <= 1'b1;
                                        end
                                        else if (expected)
                                        begin
                                                bad_cnt <= bad_nxt;
                                                if (err_cnt != '1)
                                                        err_cnt <= err_cnt + 1'b1;  // Saturates.
                                                if (bad_nxt >= i_cfg.inval_thr)
                                                begin
                                                        bad_cnt  <= '0;
                                                        o_resync <= 1'b1;
                                                        state    <= ST_SEARCH;
                                                        if (resync_cnt != '1)
                                                                resync_cnt <= resync_cnt + 1'b1;
                                                end
                                        end
                                end
                                default: state <= ST_IDLE;
                                endcase
                        end
                end
        end

        always_ff @(posedge i_clock)
        begin
                o_data <= i_data;
        end

endmodule

/* rtl/am_lane_reorder.sv */
module am_lane_reorder
        import am_pkg::*;
(
        input  logic               i_clock,
        input  logic               i_rst_n,
        input  logic               i_valid,
        input  block_t             i_data [N_LANES],
        input  lane_status_t       i_status [N_LANES],
        input  logic [N_LANES-1:0] i_start_of_lane,
        input  logic [N_LANES-1:0] i_resync,
        output logic               o_valid,
        output block_t             o_data [N_LANES],
        output logic [N_LANES-1:0] o_start_of_lane,
        output logic [N_LANES-1:0] o_am_lock,
        output logic [N_LANES-1:0] o_resync,
        output logic               o_all_aligned
);

        logic [N_LANES-1:0] lock;
        logic [N_LANES-1:0] seen;
        logic               aligned;
        lane_id_t           src [N_LANES];

        // Ids cover every logical lane only when they are a permutation.
        always_comb
        begin
                seen = '0;
                for (int p = 0; p < N_LANES; p++)
                begin
                        lock[p] = i_status[p].am_lock;
                        seen[i_status[p].lane_id] = 1'b1;
                end
                aligned = (&lock) && (&seen);
                for (int l = 0; l < N_LANES; l++)
                begin
                        src[l] = lane_id_t'(l);                 // Physical order by default.
                        for (int p = 0; p < N_LANES; p++)
                        begin
                                if (aligned && i_status[p].lane_id == lane_id_t'(l))
                                        src[l] = lane_id_t'(p);
                        end
                end
        end

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        o_valid         <= 1'b0;
                        o_start_of_lane <= '0;
                        o_am_lock       <= '0;
                        o_resync        <= '0;
                        o_all_aligned   <= 1'b0;
                end
                else
                begin
                        o_valid       <= i_valid;
                        o_am_lock     <= lock;
                        o_resync      <= i_resync;
                        o_all_aligned <= aligned;
                        for (int l = 0; l < N_LANES; l++)
                                o_start_of_lane[l] <= i_start_of_lane[src[l]];
                end
        end

        always_ff @(posedge i_clock)
        begin
                for (int l = 0; l < N_LANES; l++)
                        o_data[l] <= i_data[src[l]];
        end

endmodule

/* rtl/am_top_level.sv */
module am_top_level
        import am_pkg::*;
(
        input  logic               i_clock,
        input  logic               i_rst_n,
        input  wb_req_t            i_wb,
        output wb_rsp_t            o_wb,
        input  logic               i_valid,
        input  logic [N_LANES-1:0] i_block_lock,
        input  block_t             i_data [N_LANES],
        output logic               o_valid,
        output block_t             o_data [N_LANES],
        output logic [N_LANES-1:0] o_start_of_lane,
        output logic [N_LANES-1:0] o_am_lock,
        output logic [N_LANES-1:0] o_resync,
        output logic               o_all_aligned
);

        am_cfg_t            cfg;
        lane_status_t       status [N_LANES];
        block_t             lane_data [N_LANES];
        logic [N_LANES-1:0] lane_valid;
        logic [N_LANES-1:0] lane_sol;
        logic [N_LANES-1:0] lane_resync;

        am_csr_wb u_csr
        (
                .i_clock       (i_clock),
                .i_rst_n       (i_rst_n),
                .i_wb          (i_wb),
                .o_wb          (o_wb),
                .i_status      (status),
                .i_all_aligned (o_all_aligned),
                .o_cfg         (cfg)
        );

        for (genvar i = 0; i < N_LANES; i++)
        begin : g_lane
                am_lock_lane u_lock
                (
                        .i_clock         (i_clock),
                        .i_rst_n         (i_rst_n),
                        .i_cfg           (cfg),
                        .i_valid         (i_valid),
                        .i_block_lock    (i_block_lock[i]),
                        .i_data          (i_data[i]),
                        .o_valid         (lane_valid[i]),
                        .o_data          (lane_data[i]),
                        .o_status        (status[i]),
                        .o_resync        (lane_resync[i]),
                        .o_start_of_lane (lane_sol[i])
                );
        end

        am_lane_reorder u_reorder
        (
                .i_clock         (i_clock),
                .i_rst_n         (i_rst_n),
                .i_valid         (lane_valid[0]),       // All lanes share one valid.
                .i_data          (lane_data),
                .i_status        (status),
                .i_start_of_lane (lane_sol),
                .i_resync        (lane_resync),
                .o_valid         (o_valid),
                .o_data          (o_data),
                .o_start_of_lane (o_start_of_lane),
                .o_am_lock       (o_am_lock),
                .o_resync        (o_resync),
                .o_all_aligned   (o_all_aligned)
        );

endmodule

/* dv/am_top_chk.sv */
module am_top_chk
        import am_pkg::*;
(
        input logic               i_clock,
        input logic               i_rst_n,
        input wb_rsp_t            i_wb_rsp,
        input logic               i_valid,
        input logic [N_LANES-1:0] i_am_lock,
        input logic [N_LANES-1:0] i_resync,
        input logic               i_all_aligned
);
        timeunit 1ns;
        timeprecision 100ps;

        int fail_cnt = 0;                               // Count of failed assertions.

        ack_single: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                i_wb_rsp.ack |=> !i_wb_rsp.ack)
                else begin $error("Wishbone ack held for two cycles."); fail_cnt++; end

        aligned_locked: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                i_all_aligned |-> &i_am_lock)
                else begin $error("All-aligned high with a lane unlocked."); fail_cnt++; end

        resync_single: assert property (@(posedge i_clock) disable iff (!i_rst_n)
                (i_resync & $past(i_resync)) == '0)
                else begin $error("Resync pulse longer than one cycle."); fail_cnt++; end

        valid_in_reset: assert property (@(posedge i_clock) !i_rst_n |-> !i_valid)
                else begin $error("Output valid high during reset."); fail_cnt++; end

endmodule

bind am_top_level am_top_chk u_chk
(
        .i_clock       (i_clock),
        .i_rst_n       (i_rst_n),
        .i_wb_rsp      (o_wb),
        .i_valid       (o_valid),
        .i_am_lock     (o_am_lock),
        .i_resync      (o_resync),
        .i_all_aligned (o_all_aligned)
);

/* dv/am_tb.sv */
module am_tb
        import am_pkg::*;
();
        timeunit 1ns;
        timeprecision 100ps;

        localparam int TOTAL_BLOCKS = 544;
        localparam int MAX_CYCLES   = 3 * TOTAL_BLOCKS + 2000;
        localparam int NEVER        = 1 << 30;

        typedef struct packed {
                logic                  aligned;
                logic                  sol_chk;
                logic [N_LANES-1:0]    sol;
                logic [N_LANES-1:0]    resync;
                block_t [N_LANES-1:0]  data;            // Logical order once aligned.
        } exp_t;

        logic               clock;
        logic               rst_n;
        wb_req_t            wb_req;
        wb_rsp_t            wb_rsp;
        logic               in_valid;
        logic [N_LANES-1:0] block_lock;
        block_t             in_data [N_LANES];
        logic               out_valid;
        block_t             out_data [N_LANES];
        logic [N_LANES-1:0] out_sol;
        logic [N_LANES-1:0] out_lock;
        logic [N_LANES-1:0] out_resync;
        logic               out_aligned;

        exp_t        exp_q [$];
        lane_id_t    perm [N_LANES] = '{2'd2, 2'd0, 2'd3, 2'd1};
        am_period_t  period = 16'd16;
        am_pattern_t dc_flip = '0;                      // Applied to every marker.
        am_pattern_t bad_flip = '0;
        int          bad_lane = -1;
        int          bad_from = 0;
        int          bad_to = 0;
        int          resync_idx = -1;
        int          blk_idx = 0;                       // Valid blocks sent since restart.
        int          cycles = 0;

        am_top_level am_top_level_i
        (
                .i_clock         (clock),
                .i_rst_n         (rst_n),
                .i_wb            (wb_req),
                .o_wb            (wb_rsp),
                .i_valid         (in_valid),
                .i_block_lock    (block_lock),
                .i_data          (in_data),
                .o_valid         (out_valid),
                .o_data          (out_data),
                .o_start_of_lane (out_sol),
                .o_am_lock       (out_lock),
                .o_resync        (out_resync),
                .o_all_aligned   (out_aligned)
        );

        initial
        begin
                clock = 1'b0;
                forever #10 clock = ~clock;
        end

        always @(posedge clock)
        begin
                cycles++;
                if (cycles > MAX_CYCLES)
                begin
                        $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
                        abort_run();
                end
        end

        always @(am_top_level_i.u_chk.fail_cnt)
        begin
                if (am_top_level_i.u_chk.fail_cnt != 0)
                begin
                        $display("A bound assertion failed at %0t.", $time);
                        abort_run();
                end
        end

        task automatic abort_run();
                $display("RESULT: FAIL");
                $fatal(1, "Run stopped.");
        endtask

        task automatic check_block(input string name, input block_t got, input block_t exp);
                if (got !== exp)
                begin
                        $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_word(input string name, input wb_data_t got, input wb_data_t exp);
                if (got !== exp)
                begin
                        $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_bit(input string name, input logic got, input logic exp);
                if (got !== exp)
                begin
                        $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
                        abort_run();
                end
        endtask

        task automatic wb_write(input wb_adr_t adr, input wb_data_t dat);
                @(negedge clock);
                wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
                do @(negedge clock); while (!wb_rsp.ack);
                wb_req = '0;
        endtask

        task automatic wb_read(input wb_adr_t adr, output wb_data_t dat);
                @(negedge clock);
                wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
                do @(negedge clock); while (!wb_rsp.ack);
                dat = wb_rsp.dat;                       // Valid while ack is high.
                wb_req = '0;
        endtask

        task automatic reg_roundtrip(input wb_adr_t adr, input wb_data_t wdat, input wb_data_t exp);
                wb_data_t rd;
                wb_write(adr, wdat);
                wb_read(adr, rd);
                check_word($sformatf("wb read 0x%0h", adr), rd, exp);
        endtask

        task automatic restart_lanes();
                wb_write(ADR_CTRL, 32'h0);
                wb_write(ADR_CTRL, 32'h1);
                blk_idx = 0;
        endtask

        task automatic compare_outputs(input exp_t e);
                check_bit("o_valid", out_valid, 1'b1);
                check_bit("o_all_aligned", out_aligned, e.aligned);
                for (int l = 0; l < N_LANES; l++)
                begin
                        check_block($sformatf("o_data[%0d]", l), out_data[l], e.data[l]);
                        check_bit($sformatf("o_resync[%0d]", l), out_resync[l], e.resync[l]);
                        if (e.aligned)
                                check_bit($sformatf("o_am_lock[%0d]", l), out_lock[l], 1'b1);
                        if (e.sol_chk)
                                check_bit($sformatf("o_start_of_lane[%0d]", l), out_sol[l], e.sol[l]);
                end
        endtask

        // Physical lane p carries logical lane perm[p]; outputs are compared two cycles later.
        task automatic send_blocks(input int n, input int al_from, input int al_to);
                exp_t        e;
                block_t      blk;
                am_pattern_t pat;
                logic        mk;
                logic        bad;
                for (int i = 0; i < n + 2; i++)
                begin
                        @(negedge clock);
                        if (i >= 2)
                                compare_outputs(exp_q.pop_front());
                        if (i < n)
                        begin
                                mk = (blk_idx % int'(period)) == 0;
                                e = '0;
                                e.aligned = (blk_idx >= al_from) && (blk_idx < al_to);
                                e.sol_chk = e.aligned && (blk_idx != al_from);
                                if (blk_idx == resync_idx)
                                        e.resync[bad_lane] = 1'b1;
                                for (int p = 0; p < N_LANES; p++)
                                begin
                                        bad = (p == bad_lane) && (blk_idx >= bad_from) &&
                                              (blk_idx < bad_to);
                                        pat = AM_PATTERNS[perm[p]] ^ dc_flip;
                                        if (bad)
                                                pat = pat ^ bad_flip;
                                        if (mk)
                                                blk = {SYNC_CTRL, 16'($urandom), pat};
                                        else
                                                blk = {2'b01, 32'($urandom), 32'($urandom)};
                                        e.sol[perm[p]] = mk && !bad;
                                        in_data[p] = blk;
                                        if (e.aligned)
                                                e.data[perm[p]] = blk;
                                        else
                                                e.data[p] = blk;
                                end
                                in_valid = 1'b1;
                                exp_q.push_back(e);
                                blk_idx++;
                        end
                        else
                                in_valid = 1'b0;
                end
        endtask

        task automatic test_registers();
                wb_data_t rd;
                wb_read(ADR_STATUS, rd);
                check_word("status after reset", rd, '0);
                for (int l = 0; l < N_LANES; l++)
                begin
                        wb_read(wb_adr_t'(ADR_LANE_CNT0 + l), rd);
                        check_word($sformatf("lane %0d counters after reset", l), rd, '0);
                end
                reg_roundtrip(ADR_CTRL, 32'hffff_ffff, 32'h0000_0001);
                reg_roundtrip(ADR_CTRL, 32'hffff_fffe, 32'h0000_0000);
                reg_roundtrip(ADR_THR, 32'hffff_ffff, 32'h0000_071f);
                reg_roundtrip(ADR_MASK_LO, 32'ha5a5_5a5a, 32'ha5a5_5a5a);
                reg_roundtrip(ADR_MASK_HI, 32'hffff_1234, 32'h0000_1234);
                reg_roundtrip(ADR_PERIOD, 32'hdead_beef, 32'h0000_beef);
                for (int a = 10; a < 16; a++)
                        reg_roundtrip(wb_adr_t'(a), 32'hffff_ffff, 32'h0);
        endtask

        task automatic test_lock_reorder();
                wb_data_t rd;
                wb_data_t exp;
                wb_write(ADR_THR, 32'h0000_0303);
                wb_write(ADR_MASK_LO, 32'hffff_ffff);
                wb_write(ADR_MASK_HI, 32'h0000_ffff);
                wb_write(ADR_PERIOD, wb_data_t'(period));
                wb_write(ADR_CTRL, 32'h1);
                blk_idx = 0;
                send_blocks(64, 32, NEVER);             // Third marker sits at block 32.
                exp = 32'h1f;
                for (int p = 0; p < N_LANES; p++)
                        exp[8 + 2*p +: 2] = perm[p];
                wb_read(ADR_STATUS, rd);
                check_word("status after lock", rd, exp);
        endtask

        task automatic test_masked_compare();
                wb_write(ADR_MASK_LO, 32'hffff_ff00);
                dc_flip = 48'h0000_0000_005a;
                restart_lanes();
                send_blocks(64, 32, NEVER);
                bad_lane = 3;
                bad_flip = 48'h0000_0100_0000;
                bad_from = 16;
                bad_to   = 32;
                restart_lanes();
                send_blocks(96, 64, NEVER);             // Lane 3 restarts its search at block 16.
                bad_lane = -1;
                dc_flip  = '0;
        endtask

        task automatic test_bad_markers();
                wb_data_t rd;
                bad_lane = 0;
                bad_flip = 48'h8000_0000_0000;
                bad_from = blk_idx + 16;
                bad_to   = blk_idx + 48;
                send_blocks(64, 0, NEVER);
                wb_read(ADR_LANE_CNT0, rd);
                check_word("lane 0 counters", rd, 32'h0000_0002);
                bad_from   = blk_idx + 16;
                bad_to     = blk_idx + 64;
                resync_idx = blk_idx + 48;
                send_blocks(64, 0, resync_idx);
                check_bit("o_am_lock[0]", out_lock[0], 1'b0);
                wb_read(ADR_STATUS, rd);
                check_bit("status lock[0]", rd[0], 1'b0);
                check_bit("status aligned", rd[STATUS_ALIGNED_BIT], 1'b0);
                bad_lane   = -1;
                resync_idx = -1;
                send_blocks(64, blk_idx + 32, NEVER);
                wb_read(ADR_LANE_CNT0, rd);
                check_word("lane 0 counters", rd, 32'h0001_0005);
        endtask

        task automatic test_disable();
                wb_data_t rd;
                @(negedge clock);
                block_lock[0] = 1'b0;
                repeat (3) @(negedge clock);
                check_bit("o_am_lock[0]", out_lock[0], 1'b0);
                check_bit("o_all_aligned", out_aligned, 1'b0);
                wb_read(ADR_STATUS, rd);
                check_bit("status lock[0]", rd[0], 1'b0);
                block_lock[0] = 1'b1;
                send_blocks(64, blk_idx + 32, NEVER);
                wb_read(ADR_LANE_CNT0, rd);
                check_word("lane 0 counters", rd, 32'h0001_0005);
                wb_write(ADR_CTRL, 32'h0);
                repeat (3) @(negedge clock);
                for (int l = 0; l < N_LANES; l++)
                        check_bit($sformatf("o_am_lock[%0d]", l), out_lock[l], 1'b0);
                check_bit("o_all_aligned", out_aligned, 1'b0);
                wb_write(ADR_CTRL, 32'h1);
                blk_idx = 0;
                send_blocks(64, 32, NEVER);
                wb_read(ADR_LANE_CNT0, rd);
                check_word("lane 0 counters", rd, 32'h0001_0005);
        endtask

        initial
        begin
                void'($urandom(24041));
                rst_n      = 1'b0;
                wb_req     = '0;
                in_valid   = 1'b0;
                block_lock = '1;
                for (int l = 0; l < N_LANES; l++)
                        in_data[l] = '0;
                repeat (16) @(negedge clock);
                rst_n = 1'b1;
                test_registers();
                test_lock_reorder();
                test_masked_compare();
                test_bad_markers();
                test_disable();
                $display("RESULT: PASS");
                $finish;
        end

endmodule

/* sim.f */
rtl/am_pkg.sv
rtl/am_csr_wb.sv
rtl/am_lock_lane.sv
rtl/am_lane_reorder.sv
rtl/am_top_level.sv
dv/am_top_chk.sv
dv/am_tb.sv

/* Bender.yml */
package:
  name: am_lock

sources:
  - rtl/am_pkg.sv
  - rtl/am_csr_wb.sv
  - rtl/am_lock_lane.sv
  - rtl/am_lane_reorder.sv
  - rtl/am_top_level.sv
  - target: test
    files:
      - dv/am_top_chk.sv
      - dv/am_tb.sv
